// ==== common/cache_pkg.sv ====
package cache_pkg;

	// Address and word geometry
	localparam int addr_width = 16;
	localparam int word_width = 16;
	localparam int bytes_per_word = word_width / 8;

	// Line and set geometry
	localparam int line_words = 8;
	localparam int line_width = line_words * word_width; // 128 bits per line
	localparam int num_sets = 8;
	localparam int index_width = 3;
	localparam int num_ways = 2; // LRU is a single bit per set
	localparam int offset_width = 4; // Byte offset within a line
	localparam int tag_width = addr_width - index_width - offset_width;

	// CPU side request, held stable until resp
	typedef struct packed {
		logic read;
		logic write;
		logic [bytes_per_word-1:0] byte_enable;
		logic [addr_width-1:0] address;
		logic [word_width-1:0] wdata;
	} cpu_req_t;

	// CPU side response, resp is a single cycle pulse
	typedef struct packed {
		logic resp;
		logic [word_width-1:0] rdata;
	} cpu_rsp_t;

	// Memory side request, one whole line per transaction
	typedef struct packed {
		logic read;
		logic write;
		logic [addr_width-1:0] address; // Line aligned
		logic [line_width-1:0] wdata;
	} pmem_req_t;

	// Memory side response
	typedef struct packed {
		logic resp;
		logic [line_width-1:0] rdata;
	} pmem_rsp_t;

endpackage

// ==== cache/cache_datapath.sv ====
`timescale 1ns/1ps

module cache_datapath (
	input logic clk,
	input logic reset,
	input cache_pkg::cpu_req_t cpu_req,
	output logic [cache_pkg::word_width-1:0] rdata,
	output logic hit,
	output logic victim_dirty,
	input logic load_word,
	input logic load_fill,
	input logic update_lru,
	output logic [cache_pkg::addr_width-1:0] victim_addr,
	output logic [cache_pkg::line_width-1:0] victim_data,
	input logic [cache_pkg::line_width-1:0] fill_data
);

	// Storage arrays
	logic [cache_pkg::line_width-1:0] data_array [cache_pkg::num_sets][cache_pkg::num_ways];
	logic [cache_pkg::tag_width-1:0] tag_array [cache_pkg::num_sets][cache_pkg::num_ways];
	logic [cache_pkg::num_sets-1:0][cache_pkg::num_ways-1:0] valid_bits;
	logic [cache_pkg::num_sets-1:0][cache_pkg::num_ways-1:0] dirty_bits;
	logic [cache_pkg::num_sets-1:0] lru_bits; // Names the way to evict next

	// Address fields
	logic [cache_pkg::tag_width-1:0] req_tag;
	logic [cache_pkg::index_width-1:0] index;
	logic [cache_pkg::offset_width-2:0] word_sel; // Word within line

	logic [cache_pkg::num_ways-1:0] way_hit;
	logic hit_way;
	logic victim_way;
	logic [cache_pkg::line_width-1:0] hit_line;
	logic [cache_pkg::line_width-1:0] merged_line;

	assign req_tag = cpu_req.address[cache_pkg::addr_width-1 -: cache_pkg::tag_width];
	assign index = cpu_req.address[cache_pkg::offset_width +: cache_pkg::index_width];
	assign word_sel = cpu_req.address[cache_pkg::offset_width-1:1]; // Bit 0 is byte select

	// Tag compare per way, qualified by valid
	always_comb begin
		for (int w = 0; w < cache_pkg::num_ways; w++) begin
			way_hit[w] = valid_bits[index][w] && (tag_array[index][w] == req_tag);
		end
	end

	assign hit = |way_hit;
	assign hit_way = way_hit[1]; // Two ways, so way 1 or else way 0
	assign victim_way = lru_bits[index];

	// Read word out of the hit line
	assign hit_line = data_array[index][hit_way];
	assign rdata = hit_line[word_sel*cache_pkg::word_width +: cache_pkg::word_width];

	// Store data merged into the hit line under byte enables
	always_comb begin
		merged_line = hit_line;
		for (int b = 0; b < cache_pkg::bytes_per_word; b++) begin
			if (cpu_req.byte_enable[b]) begin
				merged_line[word_sel*cache_pkg::word_width + b*8 +: 8] = cpu_req.wdata[b*8 +: 8];
			end
		end
	end

	// Write-back source, the LRU way of the indexed set
	assign victim_dirty = valid_bits[index][victim_way] && dirty_bits[index][victim_way];
	assign victim_addr = {tag_array[index][victim_way], index, {cache_pkg::offset_width{1'b0}}};
	assign victim_data = data_array[index][victim_way];

	// Line and tag storage
	always_ff @(posedge clk) begin
		if (load_fill) begin
			data_array[index][victim_way] <= fill_data; // New line over victim
			tag_array[index][victim_way] <= req_tag;
		end else if (load_word) begin
			data_array[index][hit_way] <= merged_line; // Store hit
		end
	end

	// Valid, dirty and LRU state
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_bits <= '0;
			dirty_bits <= '0;
			lru_bits <= '0;
		end else begin
			if (load_fill) begin
				valid_bits[index][victim_way] <= 1'b1;
				dirty_bits[index][victim_way] <= 1'b0; // Fresh line is clean
			end else if (load_word) begin
				dirty_bits[index][hit_way] <= 1'b1;
			end
			if (update_lru) begin
				lru_bits[index] <= ~hit_way; // Other way becomes LRU
			end
		end
	end

endmodule

// ==== cache/cache_control.sv ====
`timescale 1ns/1ps

module cache_control (
	input logic clk,
	input logic reset,
	input cache_pkg::cpu_req_t cpu_req,
	output logic resp,
	input logic hit,
	input logic victim_dirty,
	output logic load_word,
	output logic load_fill,
	output logic update_lru,
	output logic pmem_read,
	output logic pmem_write,
	input logic pmem_resp
);

	typedef enum logic [1:0] {
		st_idle,
		st_respond,
		st_write_back,
		st_fill
	} state_t;

	state_t state;
	state_t next_state;
	logic cpu_access;

	assign cpu_access = cpu_req.read || cpu_req.write;

	// Next state and outputs
	always_comb begin
		next_state = state;
		resp = 1'b0;
		load_word = 1'b0;
		load_fill = 1'b0;
		update_lru = 1'b0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		case (state)
			st_idle: begin
				if (cpu_access) begin
					if (hit) begin
						next_state = st_respond;
					end else if (victim_dirty) begin
						next_state = st_write_back; // Evict before refill
					end else begin
						next_state = st_fill;
					end
				end
			end
			st_respond: begin
				resp = 1'b1; // Read word valid this cycle
				load_word = cpu_req.write;
				update_lru = 1'b1;
				next_state = st_idle;
			end
			st_write_back: begin
				pmem_write = 1'b1;
				if (pmem_resp) next_state = st_fill;
			end
			st_fill: begin
				pmem_read = 1'b1;
				load_fill = pmem_resp; // Line captured on resp edge
				if (pmem_resp) next_state = st_idle; // Retry as a hit
			end
			default: next_state = st_idle;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) state <= st_idle;
		else state <= next_state;
	end

endmodule

// ==== cache/cache.sv ====
`timescale 1ns/1ps

module cache (
	input logic clk,
	input logic reset,
	input cache_pkg::cpu_req_t cpu_req,
	output cache_pkg::cpu_rsp_t cpu_rsp,
	output cache_pkg::pmem_req_t pmem_req,
	input cache_pkg::pmem_rsp_t pmem_rsp
);

	logic hit;
	logic victim_dirty;
	logic load_word;
	logic load_fill;
	logic update_lru;
	logic pmem_read;
	logic pmem_write;
	logic [cache_pkg::addr_width-1:0] victim_addr;
	logic [cache_pkg::addr_width-1:0] fill_addr;
	logic [cache_pkg::line_width-1:0] victim_data;

	// Request address with byte offset cleared
	assign fill_addr = {cpu_req.address[cache_pkg::addr_width-1:cache_pkg::offset_width],
		{cache_pkg::offset_width{1'b0}}};

	assign pmem_req.read = pmem_read;
	assign pmem_req.write = pmem_write;
	assign pmem_req.address = pmem_write ? victim_addr : fill_addr; // Victim on write-back
	assign pmem_req.wdata = victim_data;

	cache_datapath datapath_i (
		.clk(clk),
		.reset(reset),
		.cpu_req(cpu_req),
		.rdata(cpu_rsp.rdata),
		.hit(hit),
		.victim_dirty(victim_dirty),
		.load_word(load_word),
		.load_fill(load_fill),
		.update_lru(update_lru),
		.victim_addr(victim_addr),
		.victim_data(victim_data),
		.fill_data(pmem_rsp.rdata)
	);

	cache_control control_i (
		.clk(clk),
		.reset(reset),
		.cpu_req(cpu_req),
		.resp(cpu_rsp.resp),
		.hit(hit),
		.victim_dirty(victim_dirty),
		.load_word(load_word),
		.load_fill(load_fill),
		.update_lru(update_lru),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write),
		.pmem_resp(pmem_rsp.resp)
	);

endmodule

// ==== rtl/pmem_arbiter.sv ====
`timescale 1ns/1ps

module pmem_arbiter (
	input logic clk,
	input logic reset,
	input cache_pkg::pmem_req_t req_a,
	input cache_pkg::pmem_req_t req_b,
	output cache_pkg::pmem_rsp_t rsp_a,
	output cache_pkg::pmem_rsp_t rsp_b,
	output cache_pkg::pmem_req_t mem_req,
	input cache_pkg::pmem_rsp_t mem_rsp
);

	logic busy; // Transaction in flight
	logic [1:0] grant; // Bit 0 port a, bit 1 port b
	logic last_served; // Set when port b went last
	logic want_a;
	logic want_b;
	logic pick_b;

	assign want_a = req_a.read || req_a.write;
	assign want_b = req_b.read || req_b.write;
	assign pick_b = want_b && (!want_a || !last_served); // Tie goes to the other side

	// Grant latched when idle, held until memory resp
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy <= 1'b0;
			grant <= '0;
			last_served <= 1'b1; // Port a wins first tie
		end else if (!busy) begin
			if (want_a || want_b) begin
				busy <= 1'b1;
				grant <= pick_b ? 2'b10 : 2'b01;
			end
		end else if (mem_rsp.resp) begin
			busy <= 1'b0;
			grant <= '0;
			last_served <= grant[1];
		end
	end

	// Steer request out and response back to the granted side only
	always_comb begin
		mem_req = '0;
		rsp_a = '0;
		rsp_b = '0;
		if (grant[0]) begin
			mem_req = req_a;
			rsp_a = mem_rsp;
		end else if (grant[1]) begin
			mem_req = req_b;
			rsp_b = mem_rsp;
		end
	end

endmodule

// ==== rtl/cache_subsystem.sv ====
`timescale 1ns/1ps

module cache_subsystem (
	input logic clk,
	input logic reset,
	input cache_pkg::cpu_req_t cpu_req_a,
	input cache_pkg::cpu_req_t cpu_req_b,
	output cache_pkg::cpu_rsp_t cpu_rsp_a,
	output cache_pkg::cpu_rsp_t cpu_rsp_b,
	output cache_pkg::pmem_req_t pmem_req,
	input cache_pkg::pmem_rsp_t pmem_rsp
);

	// Per cache memory side
	cache_pkg::pmem_req_t pmem_req_a;
	cache_pkg::pmem_req_t pmem_req_b;
	cache_pkg::pmem_rsp_t pmem_rsp_a;
	cache_pkg::pmem_rsp_t pmem_rsp_b;

	cache cache_a ( // Instruction side
		.clk(clk),
		.reset(reset),
		.cpu_req(cpu_req_a),
		.cpu_rsp(cpu_rsp_a),
		.pmem_req(pmem_req_a),
		.pmem_rsp(pmem_rsp_a)
	);

	cache cache_b ( // Data side
		.clk(clk),
		.reset(reset),
		.cpu_req(cpu_req_b),
		.cpu_rsp(cpu_rsp_b),
		.pmem_req(pmem_req_b),
		.pmem_rsp(pmem_rsp_b)
	);

	pmem_arbiter arbiter_i (
		.clk(clk),
		.reset(reset),
		.req_a(pmem_req_a),
		.req_b(pmem_req_b),
		.rsp_a(pmem_rsp_a),
		.rsp_b(pmem_rsp_b),
		.mem_req(pmem_req),
		.mem_rsp(pmem_rsp)
	);

endmodule

// ==== tb/pmem_arbiter_asserts.sv ====
`timescale 1ns/1ps

module pmem_arbiter_asserts (
	input logic clk,
	input logic reset,
	input cache_pkg::pmem_rsp_t rsp_a,
	input cache_pkg::pmem_rsp_t rsp_b,
	input cache_pkg::pmem_req_t mem_req,
	input cache_pkg::pmem_rsp_t mem_rsp
);

	int assert_errors = 0; // Failed assertion count

	// Each memory resp reaches exactly one cache
	resp_one_side: assert property (@(posedge clk) disable iff (reset)
		mem_rsp.resp |-> $onehot({rsp_a.resp, rsp_b.resp}))
		else begin
			$error("memory resp steered to both caches or to neither");
			assert_errors++;
		end

	// Read and write never together on the shared port
	read_write_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(mem_req.read && mem_req.write))
		else begin
			$error("memory request has read and write together");
			assert_errors++;
		end

	// Forwarded request held until memory resp
	request_stable: assert property (@(posedge clk) disable iff (reset)
		(mem_req.read || mem_req.write) && !mem_rsp.resp |=> $stable(mem_req))
		else begin
			$error("granted memory request changed before resp");
			assert_errors++;
		end

endmodule

bind pmem_arbiter pmem_arbiter_asserts arbiter_asserts_i (
	.clk(clk),
	.reset(reset),
	.rsp_a(rsp_a),
	.rsp_b(rsp_b),
	.mem_req(mem_req),
	.mem_rsp(mem_rsp)
);

// ==== tb/cache_checker.sv ====
`timescale 1ns/1ps

module cache_checker (
	input logic clk,
	input logic reset,
	input cache_pkg::cpu_req_t cpu_req_a,
	input cache_pkg::cpu_req_t cpu_req_b,
	input cache_pkg::cpu_rsp_t cpu_rsp_a,
	input cache_pkg::cpu_rsp_t cpu_rsp_b,
	input cache_pkg::pmem_req_t pmem_req,
	input cache_pkg::pmem_rsp_t pmem_rsp,
	output int data_errors,
	output int wb_errors,
	output int timing_errors,
	output int reset_errors
);

	logic [15:0] model [2][16384]; // Expected words, port a then port b
	logic [4095:0] written; // Line stored to since its fill
	logic [4095:0] seen; // Line touched since reset
	int cycles [2]; // Edges since request start
	int mem_ops [2]; // Memory transactions in current access
	logic fill_seen [2]; // Own line filled in current access
	logic [11:0] last_line [2];
	logic last_valid [2];

	// Power-on memory word by word address
	function automatic logic [15:0] init_word(input logic [14:0] word_addr);
		return ({1'b0, word_addr} * 16'h9e37) ^ 16'h3c5a;
	endfunction

	initial begin
		for (int p = 0; p < 2; p++) begin
			for (int i = 0; i < 16384; i++) begin
				model[p][i] = init_word({p[0], i[13:0]});
			end
			cycles[p] = 0;
			mem_ops[p] = 0;
			fill_seen[p] = 1'b0;
			last_line[p] = '0;
			last_valid[p] = 1'b0;
		end
		written = '0;
		seen = '0;
		data_errors = 0;
		wb_errors = 0;
		timing_errors = 0;
		reset_errors = 0;
	end

	always @(posedge clk) begin
		cache_pkg::cpu_req_t req;
		cache_pkg::cpu_rsp_t rsp;
		logic pi;
		logic [11:0] line;
		logic [11:0] mem_line;
		logic [13:0] wi;
		logic [127:0] expect_line;
		mem_line = pmem_req.address[15:4];
		if (reset) begin
			if (cpu_rsp_a.resp || cpu_rsp_b.resp || pmem_req.read || pmem_req.write) begin
				$display("[ERROR] %0t: resp or memory request high during reset", $time);
				reset_errors++;
			end
		end else begin
			// Memory side, checked on the resp edge
			if (pmem_rsp.resp) begin
				mem_ops[mem_line[11]]++;
				if (pmem_req.address[3:0] != 4'h0) begin
					$display("[ERROR] %0t: memory address %h not line aligned", $time,
						pmem_req.address);
					wb_errors++;
				end
				if (pmem_req.write) begin
					for (int w = 0; w < 8; w++) begin
						expect_line[w*16 +: 16] = model[mem_line[11]][{mem_line[10:0], w[2:0]}];
					end
					if (!written[mem_line]) begin
						$display("[ERROR] %0t: write-back of clean line %h", $time, mem_line);
						wb_errors++;
					end
					if (pmem_req.wdata != expect_line) begin
						$display("[ERROR] %0t: write-back line %h data %h, expected %h", $time,
							mem_line, pmem_req.wdata, expect_line);
						wb_errors++;
					end
				end
				written[mem_line] = 1'b0; // Line leaves or enters clean
			end
			// CPU side per port
			for (int p = 0; p < 2; p++) begin
				pi = p[0];
				req = pi ? cpu_req_b : cpu_req_a;
				rsp = pi ? cpu_rsp_b : cpu_rsp_a;
				line = req.address[15:4];
				wi = req.address[14:1];
				if (req.read || req.write) begin
					if (pmem_rsp.resp && pmem_req.read && mem_line == line) fill_seen[pi] = 1'b1;
					if (!rsp.resp) begin
						cycles[pi]++;
					end else begin
						if (req.read && rsp.rdata != model[pi][wi]) begin
							$display("[ERROR] %0t: port %0d read %h returned %h, expected %h",
								$time, pi, req.address, rsp.rdata, model[pi][wi]);
							data_errors++;
						end
						if (req.write) begin
							for (int b = 0; b < 2; b++) begin
								if (req.byte_enable[b]) model[pi][wi][b*8 +: 8] = req.wdata[b*8 +: 8];
							end
							written[line] = 1'b1;
						end
						// Same line twice in a row must hit
						if (last_valid[pi] && last_line[pi] == line &&
							(cycles[pi] != 1 || mem_ops[pi] != 0)) begin
							$display("[ERROR] %0t: port %0d line %h repeat %0d cycles %0d mem ops",
								$time, pi, line, cycles[pi], mem_ops[pi]);
							timing_errors++;
						end
						if (!seen[line] && !fill_seen[pi]) begin
							$display("[ERROR] %0t: first access to line %h made no memory read",
								$time, line);
							timing_errors++;
						end
						seen[line] = 1'b1;
						last_line[pi] = line;
						last_valid[pi] = 1'b1;
						cycles[pi] = 0;
						mem_ops[pi] = 0;
						fill_seen[pi] = 1'b0;
					end
				end
			end
		end
	end

endmodule

// ==== tb/tb_cache_subsystem.sv ====
`timescale 1ns/1ps

module tb_cache_subsystem;

	logic clk = 1'b0;
	logic reset = 1'b1;
	cache_pkg::cpu_req_t cpu_req_a = '0;
	cache_pkg::cpu_req_t cpu_req_b = '0;
	cache_pkg::cpu_rsp_t cpu_rsp_a;
	cache_pkg::cpu_rsp_t cpu_rsp_b;
	cache_pkg::pmem_req_t pmem_req;
	cache_pkg::pmem_rsp_t pmem_rsp = '0;

	logic [127:0] mem [4096]; // Whole 64 KB address space as lines
	logic mem_busy = 1'b0;
	int mem_wait = 0;
	integer seed = 65;
	int access_count = 400; // Per port
	int timeout_cycles = 500;
	int timeouts = 0;
	int data_errors;
	int wb_errors;
	int timing_errors;
	int reset_errors;

	always #2 clk = ~clk;

	cache_subsystem dut_i (
		.clk(clk),
		.reset(reset),
		.cpu_req_a(cpu_req_a),
		.cpu_req_b(cpu_req_b),
		.cpu_rsp_a(cpu_rsp_a),
		.cpu_rsp_b(cpu_rsp_b),
		.pmem_req(pmem_req),
		.pmem_rsp(pmem_rsp)
	);

	cache_checker checker_i (
		.clk(clk),
		.reset(reset),
		.cpu_req_a(cpu_req_a),
		.cpu_req_b(cpu_req_b),
		.cpu_rsp_a(cpu_rsp_a),
		.cpu_rsp_b(cpu_rsp_b),
		.pmem_req(pmem_req),
		.pmem_rsp(pmem_rsp),
		.data_errors(data_errors),
		.wb_errors(wb_errors),
		.timing_errors(timing_errors),
		.reset_errors(reset_errors)
	);

	// Power-on memory word by word address
	function automatic logic [15:0] init_word(input logic [14:0] word_addr);
		return ({1'b0, word_addr} * 16'h9e37) ^ 16'h3c5a;
	endfunction

	initial begin
		for (int l = 0; l < 4096; l++) begin
			for (int w = 0; w < 8; w++) begin
				mem[l][w*16 +: 16] = init_word({l[11:0], w[2:0]});
			end
		end
	end

	// Memory model, answers after 1 to 6 cycles
	always @(posedge clk) begin
		if (reset) begin
			pmem_rsp <= '0;
			mem_busy <= 1'b0;
		end else if (pmem_rsp.resp) begin
			pmem_rsp.resp <= 1'b0; // One cycle pulse
			mem_busy <= 1'b0;
		end else if (!mem_busy) begin
			if (pmem_req.read || pmem_req.write) begin
				mem_busy <= 1'b1;
				mem_wait <= 1 + ({$random(seed)} % 6);
			end
		end else if (mem_wait > 1) begin
			mem_wait <= mem_wait - 1;
		end else begin
			if (pmem_req.write) mem[pmem_req.address[15:4]] <= pmem_req.wdata;
			else pmem_rsp.rdata <= mem[pmem_req.address[15:4]];
			pmem_rsp.resp <= 1'b1;
		end
	end

	// Random accesses on one port, a few colliding tags per set
	task automatic run_port(input logic port);
		cache_pkg::cpu_req_t req;
		logic [31:0] r;
		logic [8:0] tag;
		logic [2:0] index;
		logic resp_seen;
		int cycles;
		tag = {port, 8'h05};
		index = 3'd0;
		for (int n = 0; n < access_count; n++) begin
			r = $random(seed);
			if (r[9:8] != 2'b00 || n == 0) begin // Else reuse the last line
				tag = {port, r[1:0], 6'h05}; // Top bit keeps ports apart
				index = r[4:2];
			end
			req.read = r[10];
			req.write = !r[10];
			req.byte_enable = (r[10] || r[12:11] == 2'b00) ? 2'b11 : r[12:11];
			req.address = {tag, index, r[7:5], 1'b0};
			req.wdata = r[31:16];
			if (port) cpu_req_b <= req;
			else cpu_req_a <= req;
			cycles = 0;
			resp_seen = 1'b0;
			while (!resp_seen && cycles < timeout_cycles) begin
				@(posedge clk);
				cycles++;
				resp_seen = port ? cpu_rsp_b.resp : cpu_rsp_a.resp;
			end
			if (!resp_seen) begin
				$display("Timeout: port %0d got no response within %0d cycles", port,
					timeout_cycles);
				timeouts++;
				return;
			end
			if (r[14]) begin // Idle cycle between accesses
				if (port) cpu_req_b <= '0;
				else cpu_req_a <= '0;
				@(posedge clk);
			end
		end
		if (port) cpu_req_b <= '0;
		else cpu_req_a <= '0;
	endtask

	initial begin
		int total;
		int assert_errors;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		fork
			run_port(1'b0);
			run_port(1'b1);
		join
		@(posedge clk); // Checker sees last resp
		assert_errors = dut_i.arbiter_i.arbiter_asserts_i.assert_errors;
		total = data_errors + wb_errors + timing_errors + reset_errors + timeouts +
			assert_errors;
		$display("Errors: data %0d, wb %0d, timing %0d, reset %0d, timeout %0d, assert %0d",
			data_errors, wb_errors, timing_errors, reset_errors, timeouts, assert_errors);
		if (total == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== project.f ====
common/cache_pkg.sv
cache/cache_datapath.sv
cache/cache_control.sv
cache/cache.sv
rtl/pmem_arbiter.sv
rtl/cache_subsystem.sv
tb/pmem_arbiter_asserts.sv
tb/cache_checker.sv
tb/tb_cache_subsystem.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = tb_cache_subsystem
FILELIST = project.f
OBJ_DIR = obj_dir
PASS_MSG = ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
